// File: logic/conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

module conv_mac (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    loaded,
    input  wire pe_pkg::filt_len_t filt_len_q,
    input  wire pe_pkg::if_len_t   if_len_q,
    input  wire pe_pkg::stride_t   stride_q,
    input  wire                    accumulate_in,
    input  wire pe_pkg::psum_t     psum_in,
    input  wire                    outbuf_full,
    output pe_pkg::psum_t          out_data,
    output logic                   out_write,
    output logic                   done,
    spad_rd_if.mac                 rd
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CHECK,
        M_ISSUE,
        M_DRAIN,
        M_DONE
    } state_t;

    state_t            state;

    pe_pkg::filt_len_t filt_len_r;
    pe_pkg::if_len_t   if_len_r;
    pe_pkg::stride_t   stride_r;

    // Address generator
    pe_pkg::if_len_t   win_start;
    pe_pkg::if_len_t   next_start;
    pe_pkg::if_len_t   if_addr_full;
    pe_pkg::filt_len_t tap;
    logic              tap_first;
    logic              tap_last;
    logic              last_window;
    logic              issue;

    // Read stage and product stage tags
    logic              s1_valid;
    logic              s1_first;
    logic              s1_last;
    logic              p_valid;
    logic              p_first;
    logic              p_last;
    pe_pkg::prod_t     prod_q;

    // Accumulator and presented result
    pe_pkg::psum_t     acc_q;
    pe_pkg::psum_t     acc_base;
    logic              res_valid;
    logic              stall;
    logic              pipe_empty;

    // A blocked result freezes every stage
    assign stall = res_valid && outbuf_full;
    assign issue = (state == M_ISSUE) && !stall;

    assign tap_first    = (tap == '0);
    assign tap_last     = (pe_pkg::filt_len_t'(tap + 1'b1) == filt_len_r);
    assign next_start   = win_start + pe_pkg::if_len_t'(stride_r);
    assign last_window  = (next_start + pe_pkg::if_len_t'(filt_len_r)) > if_len_r;
    assign if_addr_full = win_start + pe_pkg::if_len_t'(tap);

    assign rd.ren        = issue;
    assign rd.if_raddr   = if_addr_full[pe_pkg::IF_ADDR_LEN-1:0];
    assign rd.filt_raddr = tap[pe_pkg::FILT_ADDR_LEN-1:0];

    // Nothing left in flight once the final result goes out this cycle
    assign pipe_empty = !s1_valid && !p_valid && (!res_valid || out_write);

    assign acc_base  = accumulate_in ? psum_in : '0;
    assign out_data  = acc_q;
    assign out_write = res_valid && !outbuf_full;
    assign done      = (state == M_DONE);

    always_ff @(posedge clk) begin
        if (loaded) begin
            filt_len_r <= filt_len_q;
            if_len_r   <= if_len_q;
            stride_r   <= stride_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= M_IDLE;
            win_start <= '0;
            tap       <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (loaded) begin
                        state     <= M_CHECK;
                        win_start <= '0;
                        tap       <= '0;
                    end
                end
                M_CHECK: begin
                    // No window at all when the filter is longer than the row
                    if (pe_pkg::if_len_t'(filt_len_r) <= if_len_r) begin
                        state <= M_ISSUE;
                    end else begin
                        state <= M_DONE;
                    end
                end
                M_ISSUE: begin
                    if (issue) begin
                        if (tap_last) begin
                            tap       <= '0;
                            win_start <= next_start;
                            if (last_window) begin
                                state <= M_DRAIN;
                            end
                        end else begin
                            tap <= tap + 1'b1;
                        end
                    end
                end
                M_DRAIN: begin
                    if (pipe_empty) begin
                        state <= M_DONE;
                    end
                end
                M_DONE: begin
                    state <= M_IDLE;
                end
                default: begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

    // Stage valid flags
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            p_valid   <= 1'b0;
            res_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid  <= issue;
            p_valid   <= s1_valid;
            res_valid <= p_valid && p_last;
        end
    end

    // Tags ride along with the data, read data is valid in the s1 cycle
    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_first <= tap_first;
            s1_last  <= tap_last;
            p_first  <= s1_first;
            p_last   <= s1_last;
            prod_q   <= pe_pkg::prod_t'(rd.filt_rdata) * pe_pkg::prod_t'(rd.if_rdata);
            if (p_valid) begin
                acc_q <= (p_first ? acc_base : acc_q) + pe_pkg::psum_t'(prod_q);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/input_loader.sv
`timescale 1ns/1ps
`default_nettype none

module input_loader (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 start,
    input  wire pe_pkg::filt_len_t filt_len,
    input  wire pe_pkg::stride_t   stride_len,
    input  wire                 run_done,
    input  wire pe_pkg::filt_word_t filt_data,
    input  wire                 filt_empty,
    input  wire pe_pkg::if_word_t   if_data,
    input  wire                 if_last,
    input  wire                 if_empty,
    output logic                filt_read,
    output logic                if_read,
    output logic                loaded,
    output pe_pkg::filt_len_t   filt_len_q,
    output pe_pkg::if_len_t     if_len_q,
    output pe_pkg::stride_t     stride_q,
    spad_wr_if.loader           wr
);

    typedef enum logic [1:0] {
        IDLE,
        LOADING,
        ANNOUNCE,
        BUSY
    } state_t;

    state_t            state;
    pe_pkg::filt_len_t filt_cnt;
    pe_pkg::if_len_t   if_cnt;
    logic              if_seen_last;
    logic              filt_complete;

    assign filt_complete = (filt_cnt == filt_len_q);

    // Both buffers drain independently, each at its own pace
    assign filt_read = (state == LOADING) && !filt_empty && !filt_complete;
    assign if_read   = (state == LOADING) && !if_empty && !if_seen_last;

    assign loaded   = (state == ANNOUNCE);
    assign if_len_q = if_cnt;

    // Each consumed head word lands in the store at the same edge
    assign wr.filt_wen   = filt_read;
    assign wr.filt_waddr = filt_cnt[pe_pkg::FILT_ADDR_LEN-1:0];
    assign wr.filt_wdata = filt_data;
    assign wr.if_wen     = if_read;
    assign wr.if_waddr   = if_cnt[pe_pkg::IF_ADDR_LEN-1:0];
    assign wr.if_wdata   = if_data;

    // Run lengths, captured once per accepted start
    always_ff @(posedge clk) begin
        if ((state == IDLE) && start) begin
            filt_len_q <= filt_len;
            stride_q   <= stride_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            filt_cnt     <= '0;
            if_cnt       <= '0;
            if_seen_last <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state        <= LOADING;
                        filt_cnt     <= '0;
                        if_cnt       <= '0;
                        if_seen_last <= 1'b0;
                    end
                end
                LOADING: begin
                    if (filt_read) begin
                        filt_cnt <= filt_cnt + 1'b1;
                    end
                    if (if_read) begin
                        if_cnt <= if_cnt + 1'b1;
                        if (if_last) begin
                            if_seen_last <= 1'b1;
                        end
                    end
                    if (filt_complete && if_seen_last) begin
                        state <= ANNOUNCE;
                    end
                end
                ANNOUNCE: begin
                    state <= BUSY;
                end
                BUSY: begin
                    // Hold off new starts until the MAC has finished
                    if (run_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/pe_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Write side of the scratch store, driven by the input loader
interface spad_wr_if;
    logic                 if_wen;
    pe_pkg::if_addr_t     if_waddr;
    pe_pkg::if_word_t     if_wdata;
    logic                 filt_wen;
    pe_pkg::filt_addr_t   filt_waddr;
    pe_pkg::filt_word_t   filt_wdata;

    modport loader (
        output if_wen,
        output if_waddr,
        output if_wdata,
        output filt_wen,
        output filt_waddr,
        output filt_wdata
    );

    modport store (
        input if_wen,
        input if_waddr,
        input if_wdata,
        input filt_wen,
        input filt_waddr,
        input filt_wdata
    );
endinterface

// Read side, one cycle of latency, data holds while ren is low
interface spad_rd_if;
    logic                 ren;
    pe_pkg::if_addr_t     if_raddr;
    pe_pkg::filt_addr_t   filt_raddr;
    pe_pkg::if_word_t     if_rdata;
    pe_pkg::filt_word_t   filt_rdata;

    modport mac (
        output ren,
        output if_raddr,
        output filt_raddr,
        input  if_rdata,
        input  filt_rdata
    );

    modport store (
        input  ren,
        input  if_raddr,
        input  filt_raddr,
        output if_rdata,
        output filt_rdata
    );
endinterface

`default_nettype wire

// File: logic/pe_pkg.sv
`default_nettype none

package pe_pkg;

    // Word widths
    localparam int IF_WIDTH   = 8;
    localparam int FILT_WIDTH = 8;

    // Scratch address widths and depths
    localparam int IF_ADDR_LEN   = 5;
    localparam int FILT_ADDR_LEN = 3;
    localparam int IF_DEPTH      = 1 << IF_ADDR_LEN;
    localparam int FILT_DEPTH    = 1 << FILT_ADDR_LEN;

    // Product and sum of up to 8 terms plus one bit for the external psum
    localparam int PROD_WIDTH = IF_WIDTH + FILT_WIDTH;
    localparam int PSUM_WIDTH = PROD_WIDTH + 1 + FILT_ADDR_LEN;

    // Length fields, one bit wider than the address so the full depth fits
    localparam int FILT_LEN_WIDTH = FILT_ADDR_LEN + 1;
    localparam int IF_LEN_WIDTH   = IF_ADDR_LEN + 1;
    localparam int STRIDE_WIDTH   = 3;

    typedef logic [IF_WIDTH-1:0]       if_word_t;
    typedef logic [FILT_WIDTH-1:0]     filt_word_t;
    typedef logic [IF_ADDR_LEN-1:0]    if_addr_t;
    typedef logic [FILT_ADDR_LEN-1:0]  filt_addr_t;
    typedef logic [PROD_WIDTH-1:0]     prod_t;
    typedef logic [PSUM_WIDTH-1:0]     psum_t;
    typedef logic [FILT_LEN_WIDTH-1:0] filt_len_t;
    typedef logic [IF_LEN_WIDTH-1:0]   if_len_t;
    typedef logic [STRIDE_WIDTH-1:0]   stride_t;

endpackage

`default_nettype wire

// File: logic/pe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pe_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,
    input  wire pe_pkg::filt_len_t  filt_len,
    input  wire pe_pkg::stride_t    stride_len,
    input  wire                     accumulate_in,
    input  wire pe_pkg::psum_t      psum_in,
    input  wire pe_pkg::filt_word_t filt_data,
    input  wire                     filt_empty,
    output wire                     filt_read,
    input  wire pe_pkg::if_word_t   if_data,
    input  wire                     if_last,
    input  wire                     if_empty,
    output wire                     if_read,
    output wire pe_pkg::psum_t      out_data,
    output wire                     out_write,
    input  wire                     outbuf_full,
    output wire                     done
);

    wire                    loaded;
    wire pe_pkg::filt_len_t filt_len_q;
    wire pe_pkg::if_len_t   if_len_q;
    wire pe_pkg::stride_t   stride_q;

    spad_wr_if wr_bus ();
    spad_rd_if rd_bus ();

    // Producer side, released again by the run's done
    input_loader loader0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .filt_len   (filt_len),
        .stride_len (stride_len),
        .run_done   (done),
        .filt_data  (filt_data),
        .filt_empty (filt_empty),
        .if_data    (if_data),
        .if_last    (if_last),
        .if_empty   (if_empty),
        .filt_read  (filt_read),
        .if_read    (if_read),
        .loaded     (loaded),
        .filt_len_q (filt_len_q),
        .if_len_q   (if_len_q),
        .stride_q   (stride_q),
        .wr         (wr_bus.loader)
    );

    scratch_store store0 (
        .clk (clk),
        .rst (rst),
        .wr  (wr_bus.store),
        .rd  (rd_bus.store)
    );

    conv_mac mac0 (
        .clk           (clk),
        .rst           (rst),
        .loaded        (loaded),
        .filt_len_q    (filt_len_q),
        .if_len_q      (if_len_q),
        .stride_q      (stride_q),
        .accumulate_in (accumulate_in),
        .psum_in       (psum_in),
        .outbuf_full   (outbuf_full),
        .out_data      (out_data),
        .out_write     (out_write),
        .done          (done),
        .rd            (rd_bus.mac)
    );

endmodule

`default_nettype wire

// File: logic/scratch_store.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_store (
    input  wire       clk,
    input  wire       rst,
    spad_wr_if.store  wr,
    spad_rd_if.store  rd
);

    pe_pkg::filt_word_t filt_mem [pe_pkg::FILT_DEPTH];
    pe_pkg::if_word_t   if_mem [pe_pkg::IF_DEPTH];

    pe_pkg::filt_word_t filt_rdata_q;
    pe_pkg::if_word_t   if_rdata_q;

    // Filter array
    always_ff @(posedge clk) begin
        if (wr.filt_wen) begin
            filt_mem[wr.filt_waddr] <= wr.filt_wdata;
        end
    end

    // Feature array
    always_ff @(posedge clk) begin
        if (wr.if_wen) begin
            if_mem[wr.if_waddr] <= wr.if_wdata;
        end
    end

    // Registered read, holds its value while ren is low
    always_ff @(posedge clk) begin
        if (rst) begin
            filt_rdata_q <= '0;
            if_rdata_q   <= '0;
        end else if (rd.ren) begin
            filt_rdata_q <= filt_mem[rd.filt_raddr];
            if_rdata_q   <= if_mem[rd.if_raddr];
        end
    end

    assign rd.filt_rdata = filt_rdata_q;
    assign rd.if_rdata   = if_rdata_q;

endmodule

`default_nettype wire

// File: pe_conv.f
logic/pe_pkg.sv
logic/pe_ifs.sv
logic/input_loader.sv
logic/scratch_store.sv
logic/conv_mac.sv
logic/pe_top.sv
sim/pe_checker.sv
sim/pe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the PE testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module pe_tb -f pe_conv.f -o pe_sim

./obj_dir/pe_sim | tee "$LOG"

if grep -q "^Test completed successfully$" "$LOG"; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// File: sim/pe_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pe_checker (
    input  wire                clk,
    input  wire                rst,
    input  wire                start,
    input  wire                filt_empty,
    input  wire                filt_read,
    input  wire                if_empty,
    input  wire                if_read,
    input  wire pe_pkg::psum_t out_data,
    input  wire                out_write,
    input  wire                outbuf_full,
    input  wire                done,
    output int                 value_errors,
    output int                 protocol_errors,
    output int                 count_errors
);

    // Data words of every run, in stream order
    int            filt_words [$];
    int            if_words [$];
    int            filt_base = 0;
    int            if_base = 0;

    // Expected results and per-run counts
    pe_pkg::psum_t exp_vals [$];
    int            run_filt [$];
    int            run_if [$];
    int            run_outs [$];
    int            val_rd = 0;
    int            run_rd = 0;

    int            n_value = 0;
    int            n_protocol = 0;
    int            n_count = 0;
    int            filt_cnt = 0;
    int            if_cnt = 0;
    int            out_cnt = 0;
    logic          started = 1'b0;

    assign value_errors    = n_value;
    assign protocol_errors = n_protocol;
    assign count_errors    = n_count;

    task automatic add_filt_word(input int word);
        filt_words.push_back(word);
    endtask

    task automatic add_if_word(input int word);
        if_words.push_back(word);
    endtask

    // Window sums from the convolution rule, one entry per output
    task automatic add_run(input int flen, input int ilen, input int strd,
                           input int acc, input int psum);
        int win;
        int sum;
        int outs;
        int j;
        outs = 0;
        win  = 0;
        while (win + flen <= ilen) begin
            sum = (acc != 0) ? psum : 0;
            for (j = 0; j < flen; j++) begin
                sum += filt_words[filt_base + j] * if_words[if_base + win + j];
            end
            exp_vals.push_back(pe_pkg::psum_t'(sum));
            outs++;
            win += strd;
        end
        run_filt.push_back(flen);
        run_if.push_back(ilen);
        run_outs.push_back(outs);
        filt_base += flen;
        if_base   += ilen;
    endtask

    task automatic report(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (!started) begin
            if (filt_read || if_read || out_write || done) begin
                n_protocol++;
                report("control output active before the first start");
            end
            started = !rst && start;
        end else begin
            if (out_write && outbuf_full) begin
                n_protocol++;
                report("out_write high while outbuf_full is high");
            end
            if (filt_read && filt_empty) begin
                n_protocol++;
                report("filt_read high while filt_empty is high");
            end
            if (if_read && if_empty) begin
                n_protocol++;
                report("if_read high while if_empty is high");
            end

            // Counts close at done, before this edge's events are added
            if (done) begin
                if (run_rd >= run_outs.size()) begin
                    n_count++;
                    report("done pulse with no run pending");
                end else begin
                    if (filt_cnt != run_filt[run_rd] || if_cnt != run_if[run_rd]
                        || out_cnt != run_outs[run_rd]) begin
                        n_count++;
                        report($sformatf("run %0d: %0d filt reads, %0d if reads, %0d outputs, %s",
                                         run_rd, filt_cnt, if_cnt, out_cnt,
                                         $sformatf("expected %0d, %0d, %0d", run_filt[run_rd],
                                                   run_if[run_rd], run_outs[run_rd])));
                    end
                    run_rd++;
                end
                filt_cnt = 0;
                if_cnt   = 0;
                out_cnt  = 0;
            end

            if (filt_read) begin
                filt_cnt++;
            end
            if (if_read) begin
                if_cnt++;
            end
            if (out_write) begin
                out_cnt++;
                if (val_rd >= exp_vals.size()) begin
                    n_value++;
                    report($sformatf("unexpected result 0x%05h", out_data));
                end else begin
                    if (out_data !== exp_vals[val_rd]) begin
                        n_value++;
                        report($sformatf("result %0d is 0x%05h, expected 0x%05h",
                                         val_rd, out_data, exp_vals[val_rd]));
                    end
                    val_rd++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/pe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pe_tb;

    localparam int          NUM_RUNS   = 40;
    localparam int          MAX_CYCLES = NUM_RUNS * 1200;
    localparam logic [31:0] SEED       = 32'heceb_fb22;

    logic               clk;
    logic               rst;
    logic               start;
    pe_pkg::filt_len_t  filt_len;
    pe_pkg::stride_t    stride_len;
    logic               accumulate_in;
    pe_pkg::psum_t      psum_in;
    pe_pkg::filt_word_t filt_data;
    logic               filt_empty;
    pe_pkg::if_word_t   if_data;
    logic               if_last;
    logic               if_empty;
    logic               outbuf_full;

    wire                filt_read;
    wire                if_read;
    wire pe_pkg::psum_t out_data;
    wire                out_write;
    wire                done;

    int                 value_errors;
    int                 protocol_errors;
    int                 count_errors;

    // Buffer contents, consumed by index instead of popping
    pe_pkg::filt_word_t filt_stream [$];
    pe_pkg::if_word_t   if_stream [$];
    int                 filt_taken = 0;
    int                 if_taken = 0;
    int                 if_end = 0;
    int                 done_count = 0;
    int                 cycle_count = 0;
    logic [31:0]        lfsr_state;

    pe_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .filt_len      (filt_len),
        .stride_len    (stride_len),
        .accumulate_in (accumulate_in),
        .psum_in       (psum_in),
        .filt_data     (filt_data),
        .filt_empty    (filt_empty),
        .filt_read     (filt_read),
        .if_data       (if_data),
        .if_last       (if_last),
        .if_empty      (if_empty),
        .if_read       (if_read),
        .out_data      (out_data),
        .out_write     (out_write),
        .outbuf_full   (outbuf_full),
        .done          (done)
    );

    pe_checker chk0 (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .filt_empty      (filt_empty),
        .filt_read       (filt_read),
        .if_empty        (if_empty),
        .if_read         (if_read),
        .out_data        (out_data),
        .out_write       (out_write),
        .outbuf_full     (outbuf_full),
        .done            (done),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .count_errors    (count_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // FWFT buffer heads with random gaps, output buffer with random back-pressure
    task automatic drive_buffers();
        logic [31:0] r;
        draw_bits(2, r);
        filt_empty = (filt_taken >= filt_stream.size()) || (r[1:0] == 2'd0);
        filt_data  = (filt_taken < filt_stream.size()) ? filt_stream[filt_taken] : '0;
        draw_bits(2, r);
        if_empty = (if_taken >= if_stream.size()) || (r[1:0] == 2'd0);
        if_data  = (if_taken < if_stream.size()) ? if_stream[if_taken] : '0;
        if_last  = (if_taken == if_end - 1);
        draw_bits(8, r);
        outbuf_full = (r[7:0] < 8'd85);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (filt_read) begin
            filt_taken++;
        end
        if (if_read) begin
            if_taken++;
        end
        if (done) begin
            done_count++;
        end
        if (cycle_count >= MAX_CYCLES) begin
            $display("Simulation timed out after %0d cycles before all runs finished",
                     cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        int          run;
        int          j;
        int          flen;
        int          ilen;
        int          strd;
        int          acc;
        int          psum;
        int          target;
        int          total;

        rst           = 1'b1;
        start         = 1'b0;
        filt_len      = '0;
        stride_len    = '0;
        accumulate_in = 1'b0;
        psum_in       = '0;
        filt_data     = '0;
        filt_empty    = 1'b1;
        if_data       = '0;
        if_last       = 1'b0;
        if_empty      = 1'b1;
        outbuf_full   = 1'b0;
        lfsr_state    = SEED;

        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (run = 0; run < NUM_RUNS; run++) begin
            draw_bits(3, r);
            flen = int'(r) + 1;
            draw_bits(5, r);
            ilen = int'(r) + 1;
            draw_bits(3, r);
            strd = (int'(r) % 7) + 1;
            draw_bits(1, r);
            acc = int'(r);
            draw_bits(19, r);
            psum = int'(r);

            for (j = 0; j < flen; j++) begin
                draw_bits(8, r);
                filt_stream.push_back(pe_pkg::filt_word_t'(r));
                chk0.add_filt_word(int'(r));
            end
            for (j = 0; j < ilen; j++) begin
                draw_bits(8, r);
                if_stream.push_back(pe_pkg::if_word_t'(r));
                chk0.add_if_word(int'(r));
            end
            if_end += ilen;
            chk0.add_run(flen, ilen, strd, acc, psum);

            // Psum settings stay put for the whole run
            filt_len      = pe_pkg::filt_len_t'(flen);
            stride_len    = pe_pkg::stride_t'(strd);
            accumulate_in = (acc != 0);
            psum_in       = pe_pkg::psum_t'(psum);
            start         = 1'b1;
            drive_buffers();
            target = done_count + 1;
            @(negedge clk);
            start = 1'b0;
            drive_buffers();
            while (done_count < target) begin
                @(negedge clk);
                drive_buffers();
            end
        end

        repeat (4) @(negedge clk);
        total = value_errors + protocol_errors + count_errors;
        $display("Errors: %0d value, %0d protocol, %0d count", value_errors,
                 protocol_errors, count_errors);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
